/* dac_pattern_gen.sv */
`timescale 1ns/1ps

module dac_pattern_gen (
  input  logic                                device_clk,
  input  logic                                reset,
  input  logic                                enable,
  output logic [jesd_tpl_pkg::frame_width-1:0] samples,
  output logic                                sample_valid,
  output logic [31:0]                         frame_count
);

  import jesd_tpl_pkg::*;

  // Sample counter c of the pattern rule, steps by samples_per_channel per frame
  logic [31:0] sample_index;

  // Frame built from the current counter, registered when enable is high
  logic [frame_width-1:0] next_samples;

  // ********************************************************
  // Pattern rule
  // ********************************************************

  // Channel 0 sample 0 sits at the most significant end of the frame.
  // Below bit 8 of c + j every nibble holds the channel number.
  // From bit 8 on the top nibble holds the channel and the low byte ramps
  always_comb begin : pattern_comb
    logic [31:0]        pos;
    logic [jesd_np-1:0] sample;
    next_samples = '0;
    for (int i = 0; i < jesd_m; i++) begin
      for (int j = 0; j < samples_per_channel; j++) begin
        pos = sample_index + 32'(j);
        if (pos[ramp_select_bit]) begin
          sample = '0;
          sample[jesd_np-1 -: 4] = 4'(i);
          sample[7:0] = pos[7:0];
        end else begin
          sample = {(jesd_np / 4){4'(i)}};
        end
        next_samples[frame_width - 1 - (i * samples_per_channel + j) * jesd_np -: jesd_np] =
          sample;
      end
    end
  end

  // ********************************************************
  // Output register and counters
  // ********************************************************

  // Valid trails enable by exactly one cycle
  always_ff @(posedge device_clk) begin
    if (reset) begin
      sample_valid <= 1'b0;
      sample_index <= '0;
      frame_count  <= '0;
    end else begin
      sample_valid <= enable;
      if (enable) begin
        sample_index <= sample_index + 32'(samples_per_channel);
        frame_count  <= frame_count + 32'd1;
      end
    end
  end

  // Payload only, it holds its last frame while the source is idle
  always_ff @(posedge device_clk) begin
    if (enable) begin
      samples <= next_samples;
    end
  end

  // A restarted source must not present a frame on the first cycle after it
  a_no_valid_after_reset : assert property (
    @(posedge device_clk) reset |=> !sample_valid
  );

endmodule

/* jesd_tpl_pkg.sv */
package jesd_tpl_pkg;

  // ********************************************************
  // Link dimensions
  // ********************************************************

  // Converter channels and lanes of the link
  localparam int jesd_m = 4;
  localparam int jesd_l = 4;

  // Bits per sample, no packed 12-bit mode here
  localparam int jesd_np = 16;

  // Octets each lane carries per device_clk cycle
  localparam int lane_bytes = 4;
  localparam int lane_width = lane_bytes * 8;

  // Samples of one channel that fit in a single frame
  localparam int samples_per_channel = (jesd_l * lane_width) / jesd_m / jesd_np;

  // Whole frame, all lanes side by side
  localparam int frame_width = jesd_l * lane_width;

  // Bits one channel occupies inside a frame
  localparam int channel_data_width = samples_per_channel * jesd_np;

  // Width of a channel number
  localparam int channel_index_width = $clog2(jesd_m);

  // Counter bit that switches the generator from channel mode to ramp mode
  localparam int ramp_select_bit = 8;

  // ********************************************************
  // Register map
  // ********************************************************

  localparam int apb_addr_width = 12;
  localparam int apb_data_width = 32;

  localparam logic [apb_addr_width-1:0] reg_ctrl          = 'h000;
  localparam logic [apb_addr_width-1:0] reg_error_count   = 'h004;
  localparam logic [apb_addr_width-1:0] reg_error_channel = 'h008;
  localparam logic [apb_addr_width-1:0] reg_frame_count   = 'h00C;

  // Bit positions inside CTRL, the clear bit drops by itself after one cycle
  localparam int ctrl_tx_enable    = 0;
  localparam int ctrl_check_enable = 1;
  localparam int ctrl_clear        = 2;

  // The error counter sticks at its maximum
  localparam int error_count_width = 16;

endpackage

/* jesd_tpl_top.sv */
`timescale 1ns/1ps

module jesd_tpl_top (
  input  logic                                                      device_clk,
  input  logic                                                      reset,
  input  logic                                                      psel,
  input  logic                                                      penable,
  input  logic                                                      pwrite,
  input  logic [jesd_tpl_pkg::apb_addr_width-1:0]                   paddr,
  input  logic [jesd_tpl_pkg::apb_data_width-1:0]                   pwdata,
  output logic [jesd_tpl_pkg::apb_data_width-1:0]                   prdata,
  output logic                                                      pready,
  output logic                                                      pslverr,
  output logic [jesd_tpl_pkg::jesd_l*jesd_tpl_pkg::lane_width-1:0] lane_data,
  output logic                                                      lane_valid,
  input  logic [jesd_tpl_pkg::jesd_l*jesd_tpl_pkg::lane_width-1:0] rx_lane_data,
  input  logic                                                      rx_lane_valid
);

  import jesd_tpl_pkg::*;

  // Control from the register block
  logic tx_enable;
  logic check_enable;
  logic clear;

  // Clear restarts the transmit counter too, so both ends start again at zero
  logic tx_restart;

  // Transmit path
  logic [frame_width-1:0] tx_samples;
  logic                   tx_sample_valid;
  logic [31:0]            tx_frame_count;

  // Receive path
  logic [frame_width-1:0]         rx_samples;
  logic                           rx_sample_valid;
  logic                           error_pulse;
  logic [channel_index_width-1:0] error_channel;

  assign tx_restart = reset | clear;

  // ********************************************************
  // Registers
  // ********************************************************

  tpl_apb_regs regs (
    .device_clk    (device_clk),
    .reset         (reset),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .error_pulse   (error_pulse),
    .error_channel (error_channel),
    .frame_count   (tx_frame_count),
    .tx_enable     (tx_enable),
    .check_enable  (check_enable),
    .clear         (clear)
  );

  // ********************************************************
  // Transmit and receive paths
  // ********************************************************

  dac_pattern_gen tx_gen (
    .device_clk   (device_clk),
    .reset        (tx_restart),
    .enable       (tx_enable),
    .samples      (tx_samples),
    .sample_valid (tx_sample_valid),
    .frame_count  (tx_frame_count)
  );

  tpl_framer framer (
    .device_clk   (device_clk),
    .reset        (reset),
    .samples      (tx_samples),
    .sample_valid (tx_sample_valid),
    .lane_data    (lane_data),
    .lane_valid   (lane_valid)
  );

  tpl_deframer deframer (
    .device_clk   (device_clk),
    .reset        (reset),
    .lane_data    (rx_lane_data),
    .lane_valid   (rx_lane_valid),
    .samples      (rx_samples),
    .sample_valid (rx_sample_valid)
  );

  pattern_checker pat_check (
    .device_clk    (device_clk),
    .reset         (reset),
    .enable        (check_enable),
    .clear         (clear),
    .samples       (rx_samples),
    .sample_valid  (rx_sample_valid),
    .error_pulse   (error_pulse),
    .error_channel (error_channel)
  );

endmodule

/* pattern_checker.sv */
`timescale 1ns/1ps

module pattern_checker (
  input  logic                                        device_clk,
  input  logic                                        reset,
  input  logic                                        enable,
  input  logic                                        clear,
  input  logic [jesd_tpl_pkg::frame_width-1:0]        samples,
  input  logic                                        sample_valid,
  output logic                                        error_pulse,
  output logic [jesd_tpl_pkg::channel_index_width-1:0] error_channel
);

  import jesd_tpl_pkg::*;

  // Reference source control
  logic ref_restart;
  logic ref_advance;

  // Expected frame, valid one cycle after the received frame was taken
  logic [frame_width-1:0] ref_samples;
  logic                   ref_valid;

  // Received frame held for the compare
  logic [frame_width-1:0] rx_frame;

  // One bit per channel, set where any sample differs
  logic [jesd_m-1:0] channel_diff;

  // ********************************************************
  // Reference generator
  // ********************************************************

  // Clear puts the reference back at counter zero
  assign ref_restart = reset | clear;

  // The reference moves on only for frames that are actually checked
  assign ref_advance = enable & sample_valid;

  dac_pattern_gen ref_gen (
    .device_clk   (device_clk),
    .reset        (ref_restart),
    .enable       (ref_advance),
    .samples      (ref_samples),
    .sample_valid (ref_valid),
    .frame_count  ()
  );

  // Line the received frame up with the registered reference output
  always_ff @(posedge device_clk) begin
    if (ref_advance) begin
      rx_frame <= samples;
    end
  end

  // ********************************************************
  // Compare
  // ********************************************************

  always_comb begin
    for (int i = 0; i < jesd_m; i++) begin
      channel_diff[i] =
        rx_frame[frame_width - 1 - i * channel_data_width -: channel_data_width] !=
        ref_samples[frame_width - 1 - i * channel_data_width -: channel_data_width];
    end
  end

  // One pulse per checked frame that differs anywhere
  assign error_pulse = ref_valid && (|channel_diff);

  // Walk down so that the lowest differing channel wins
  always_comb begin
    error_channel = '0;
    for (int i = jesd_m - 1; i >= 0; i--) begin
      if (channel_diff[i]) begin
        error_channel = channel_index_width'(i);
      end
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f src.f \
  --top-module system_tb \
  -o system_tb_sim

./obj_dir/system_tb_sim | tee sim.log

if grep -qx "TEST PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* src.f */
jesd_tpl_pkg.sv
dac_pattern_gen.sv
tpl_framer.sv
tpl_deframer.sv
pattern_checker.sv
tpl_apb_regs.sv
jesd_tpl_top.sv
system_tb.sv

/* system_tb.sv */
`timescale 1ns/1ps

module system_tb;

  import jesd_tpl_pkg::*;

  localparam int bus_width = jesd_l * lane_width;

  // DUT ports
  logic                      device_clk;
  logic                      reset;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [apb_addr_width-1:0] paddr;
  logic [apb_data_width-1:0] pwdata;
  logic [apb_data_width-1:0] prdata;
  logic                      pready;
  logic                      pslverr;
  logic [bus_width-1:0]      lane_data;
  logic                      lane_valid;
  logic [bus_width-1:0]      rx_lane_data;
  logic                      rx_lane_valid;

  // Commands loaded from the pattern file
  byte         op_q[$];
  logic [31:0] arg_a[$];
  logic [31:0] arg_b[$];
  logic [31:0] arg_c[$];

  // Pending lane corruptions where a used entry gets frame index -1
  int          inj_frame[$];
  int          inj_lane[$];
  logic [31:0] inj_mask[$];

  // Model state. model_frame counts frames since the last clear
  int     model_frame;
  int     frames_seen;
  int     cycle_count;
  int     enable_cycle;
  logic   tx_mirror;
  logic   prev_lane_valid;
  longint budget_ns;

  jesd_tpl_top dut0 (
    .device_clk    (device_clk),
    .reset         (reset),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .lane_data     (lane_data),
    .lane_valid    (lane_valid),
    .rx_lane_data  (rx_lane_data),
    .rx_lane_valid (rx_lane_valid)
  );

  always #10 device_clk = ~device_clk;

  always @(posedge device_clk) begin
    cycle_count <= cycle_count + 1;
  end

  // ********************************************************
  // Checks and reference model
  // ********************************************************

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  // One sample of channel ch at counter position pos
  function automatic logic [jesd_np-1:0] pattern_sample(input int ch, input logic [31:0] pos);
    logic [3:0] id;
    id = 4'(ch);
    if (pos[ramp_select_bit]) begin
      return {id, 4'h0, pos[7:0]};
    end
    return {id, id, id, id};
  endfunction

  // Samples are shifted in from the right, so the first one ends up at the MSB
  function automatic logic [lane_width-1:0] expected_lane_word(input logic [31:0] count,
                                                               input int lane);
    logic [frame_width-1:0] frame;
    frame = '0;
    for (int i = 0; i < jesd_m; i++) begin
      for (int j = 0; j < samples_per_channel; j++) begin
        frame = {frame[frame_width-jesd_np-1:0], pattern_sample(i, count + 32'(j))};
      end
    end
    return frame[frame_width - 1 - lane * lane_width -: lane_width];
  endfunction

  function automatic logic is_mapped(input logic [31:0] addr);
    return addr == 32'(reg_ctrl) || addr == 32'(reg_error_count) ||
           addr == 32'(reg_error_channel) || addr == 32'(reg_frame_count);
  endfunction

  // Checks every lane word against the model and loops it back with any injected mask
  always @(negedge device_clk) begin : lane_loopback
    logic [bus_width-1:0] mask;
    mask = '0;
    if (reset) begin
      rx_lane_data    <= '0;
      rx_lane_valid   <= 1'b0;
      prev_lane_valid <= 1'b0;
    end else begin
      if (lane_valid) begin
        if (!prev_lane_valid) begin
          check_value("lane_valid delay after tx_enable",
                      128'(cycle_count - enable_cycle), 128'(2));
        end
        for (int k = 0; k < jesd_l; k++) begin
          check_value($sformatf("lane_data lane %0d", k),
                      128'(lane_data[k*lane_width +: lane_width]),
                      128'(expected_lane_word(32'(samples_per_channel * model_frame), k)));
        end
        for (int n = 0; n < inj_frame.size(); n++) begin
          if (inj_frame[n] == model_frame) begin
            mask[inj_lane[n]*lane_width +: lane_width] ^= inj_mask[n];
            inj_frame[n] = -1;
          end
        end
        model_frame = model_frame + 1;
        frames_seen = frames_seen + 1;
      end
      rx_lane_data    <= lane_data ^ mask;
      rx_lane_valid   <= lane_valid;
      prev_lane_valid <= lane_valid;
    end
  end

  // ********************************************************
  // APB master and command runner
  // ********************************************************

  // A random number of idle cycles between two transfers
  task automatic idle_gap();
    repeat ($urandom % 4) @(negedge device_clk);
  endtask

  task automatic apb_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] data, input logic [31:0] expected);
    idle_gap();
    @(negedge device_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr[apb_addr_width-1:0];
    pwdata  = data;
    @(negedge device_clk);
    penable = 1'b1;
    // Halfway into the access cycle the response is settled
    #5;
    check_value("pready", 128'(pready), 128'(1));
    check_value("pslverr", 128'(pslverr), 128'(!is_mapped(addr)));
    if (!write) begin
      check_value($sformatf("prdata at 0x%03h", addr), 128'(prdata), 128'(expected));
    end
    @(negedge device_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    // Track the control bits the transfer just committed
    if (write && addr == 32'(reg_ctrl)) begin
      if (data[ctrl_clear]) begin
        model_frame = 0;
      end
      if (data[ctrl_tx_enable] && !tx_mirror) begin
        enable_cycle = cycle_count;
      end
      tx_mirror = data[ctrl_tx_enable];
    end
  endtask

  // Waits for n checked frames, then lets the pipeline drain
  task automatic run_frames(input int n);
    int target;
    target = frames_seen + n;
    while (frames_seen < target) @(posedge device_clk);
    repeat (8) @(negedge device_clk);
  endtask

  task automatic load_commands();
    int    fd;
    int    got;
    string tok;
    string rest;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    longint frames;
    longint transfers;
    longint runs;
    frames = 0;
    transfers = 0;
    runs = 0;
    fd = $fopen("test_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open test_patterns.txt");
      $display("TEST FAIL");
      $fatal(1, "Missing pattern file");
    end
    while (!$feof(fd)) begin
      a = '0;
      b = '0;
      c = '0;
      got = $fscanf(fd, "%s", tok);
      if (got != 1) break;
      if (tok.getc(0) == "#") begin
        void'($fgets(rest, fd));
        continue;
      end
      case (tok.getc(0))
        "W", "R": got = $fscanf(fd, "%h %h", a, b);
        "N":      got = $fscanf(fd, "%d", a);
        "I":      got = $fscanf(fd, "%d %d %h", a, b, c);
        "F":      got = 0;
        default: begin
          $display("Unknown command %s in test_patterns.txt", tok);
          $display("TEST FAIL");
          $fatal(1, "Bad pattern file");
        end
      endcase
      if (tok.getc(0) == "N") begin
        frames = frames + a;
        runs = runs + 1;
      end else if (tok.getc(0) != "I") begin
        transfers = transfers + 1;
      end
      op_q.push_back(tok.getc(0));
      arg_a.push_back(a);
      arg_b.push_back(b);
      arg_c.push_back(c);
    end
    $fclose(fd);
    // Two cycles per frame and generous room for each transfer and drain
    budget_ns = (frames + 4 * transfers + 10 * runs) * 40 + 2000;
  endtask

  initial begin : watchdog
    wait (budget_ns > 0);
    #(budget_ns);
    $display("Watchdog expired, the run took longer than the commands allow");
    $display("TEST FAIL");
    $fatal(1, "Timeout");
  end

  initial begin : main
    void'($urandom(77503));
    device_clk      = 1'b0;
    reset           = 1'b1;
    psel            = 1'b0;
    penable         = 1'b0;
    pwrite          = 1'b0;
    paddr           = '0;
    pwdata          = '0;
    rx_lane_data    = '0;
    rx_lane_valid   = 1'b0;
    model_frame     = 0;
    frames_seen     = 0;
    cycle_count     = 0;
    enable_cycle    = 0;
    tx_mirror       = 1'b0;
    prev_lane_valid = 1'b0;
    budget_ns       = 0;
    load_commands();
    repeat (10) @(negedge device_clk);
    reset = 1'b0;
    @(negedge device_clk);
    check_value("lane_valid after reset", 128'(lane_valid), 128'(0));
    foreach (op_q[idx]) begin
      case (op_q[idx])
        "W": apb_transfer(1'b1, arg_a[idx], arg_b[idx], 32'd0);
        "R": apb_transfer(1'b0, arg_a[idx], 32'd0, arg_b[idx]);
        "F": apb_transfer(1'b0, 32'(reg_frame_count), 32'd0, 32'(model_frame));
        "N": run_frames(int'(arg_a[idx]));
        default: begin
          inj_frame.push_back(int'(arg_a[idx]));
          inj_lane.push_back(int'(arg_b[idx]));
          inj_mask.push_back(arg_c[idx]);
        end
      endcase
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

/* test_patterns.txt */
# W addr data | R addr expected | N frames | I frame lane mask | F checks the frame count
# Addresses, data and masks are hex, frame counts and lane numbers decimal
R 000 00000000
R 004 00000000
R 00C 00000000
R 010 00000000
W 020 00000003
R 000 00000000
W 000 00000001
N 300
W 000 00000000
N 0
W 000 00000004
W 000 00000003
N 300
W 000 00000000
N 0
R 004 00000000
W 000 00000004
I 20 2 00ff0000
I 45 0 00000001
I 70 3 80000000
I 90 1 0000ff00
I 90 3 00000010
W 000 00000003
N 150
W 000 00000000
N 0
R 004 00000004
R 008 00000002
F
W 000 00000004
R 004 00000000
R 008 00000000
W 000 00000003
N 200
W 000 00000000
N 0
R 004 00000000
R 000 00000000
F

/* tpl_apb_regs.sv */
`timescale 1ns/1ps

module tpl_apb_regs (
  input  logic                                        device_clk,
  input  logic                                        reset,
  input  logic                                        psel,
  input  logic                                        penable,
  input  logic                                        pwrite,
  input  logic [jesd_tpl_pkg::apb_addr_width-1:0]     paddr,
  input  logic [jesd_tpl_pkg::apb_data_width-1:0]     pwdata,
  output logic [jesd_tpl_pkg::apb_data_width-1:0]     prdata,
  output logic                                        pready,
  output logic                                        pslverr,
  input  logic                                        error_pulse,
  input  logic [jesd_tpl_pkg::channel_index_width-1:0] error_channel,
  input  logic [31:0]                                 frame_count,
  output logic                                        tx_enable,
  output logic                                        check_enable,
  output logic                                        clear
);

  import jesd_tpl_pkg::*;

  // A transfer commits in its access phase
  logic access;
  logic addr_hit;
  logic ctrl_write;

  // Status registers
  logic [error_count_width-1:0]   error_count;
  logic [channel_index_width-1:0] first_channel;
  logic                           error_seen;

  // ********************************************************
  // Bus decode
  // ********************************************************

  // Every transfer is a setup cycle plus an access cycle with no wait states
  assign pready = 1'b1;
  assign access = psel & penable;

  always_comb begin
    case (paddr)
      reg_ctrl, reg_error_count, reg_error_channel, reg_frame_count: addr_hit = 1'b1;
      default: addr_hit = 1'b0;
    endcase
  end

  // Unmapped addresses answer with an error and are otherwise ignored
  assign pslverr = access & ~addr_hit;

  assign ctrl_write = access & pwrite & (paddr == reg_ctrl);

  // Read mux. CTRL reads back zero in the self clearing bit
  always_comb begin
    prdata = '0;
    case (paddr)
      reg_ctrl: begin
        prdata[ctrl_tx_enable]    = tx_enable;
        prdata[ctrl_check_enable] = check_enable;
      end
      reg_error_count:   prdata[error_count_width-1:0] = error_count;
      reg_error_channel: prdata[channel_index_width-1:0] = first_channel;
      reg_frame_count:   prdata = apb_data_width'(frame_count);
      default:           prdata = '0;
    endcase
  end

  // ********************************************************
  // Control register
  // ********************************************************

  // Clear is high for exactly the cycle after the write
  always_ff @(posedge device_clk) begin
    if (reset) begin
      tx_enable    <= 1'b0;
      check_enable <= 1'b0;
      clear        <= 1'b0;
    end else begin
      clear <= ctrl_write & pwdata[ctrl_clear];
      if (ctrl_write) begin
        tx_enable    <= pwdata[ctrl_tx_enable];
        check_enable <= pwdata[ctrl_check_enable];
      end
    end
  end

  // ********************************************************
  // Error status
  // ********************************************************

  // Saturating count, and the channel of the first error since clear
  always_ff @(posedge device_clk) begin
    if (reset || clear) begin
      error_count   <= '0;
      first_channel <= '0;
      error_seen    <= 1'b0;
    end else if (error_pulse) begin
      if (error_count != {error_count_width{1'b1}}) begin
        error_count <= error_count + 1'b1;
      end
      if (!error_seen) begin
        first_channel <= error_channel;
        error_seen    <= 1'b1;
      end
    end
  end

  // A master raises penable only in a transfer it has already selected
  a_penable_needs_psel : assert property (
    @(posedge device_clk) disable iff (reset) $rose(penable) |-> psel
  );

endmodule

/* tpl_deframer.sv */
`timescale 1ns/1ps

module tpl_deframer (
  input  logic                                                      device_clk,
  input  logic                                                      reset,
  input  logic [jesd_tpl_pkg::jesd_l*jesd_tpl_pkg::lane_width-1:0] lane_data,
  input  logic                                                      lane_valid,
  output logic [jesd_tpl_pkg::frame_width-1:0]                      samples,
  output logic                                                      sample_valid
);

  import jesd_tpl_pkg::*;

  // Rebuilt frame, before the register
  logic [frame_width-1:0] frame_next;

  // ********************************************************
  // Inverse octet mapping
  // ********************************************************

  // Exactly the framer mapping run backwards.
  // Octet b of lane k goes back to frame octet lane_bytes*k + b
  always_comb begin
    frame_next = '0;
    for (int k = 0; k < jesd_l; k++) begin
      for (int b = 0; b < lane_bytes; b++) begin
        frame_next[frame_width - 1 - 8 * (k * lane_bytes + b) -: 8] =
          lane_data[k * lane_width + lane_width - 1 - 8 * b -: 8];
      end
    end
  end

  // Valid goes through the same single stage as the data
  always_ff @(posedge device_clk) begin
    if (reset) begin
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= lane_valid;
    end
  end

  // Sample payload, no reset needed
  always_ff @(posedge device_clk) begin
    samples <= frame_next;
  end

endmodule

/* tpl_framer.sv */
`timescale 1ns/1ps

module tpl_framer (
  input  logic                                                      device_clk,
  input  logic                                                      reset,
  input  logic [jesd_tpl_pkg::frame_width-1:0]                      samples,
  input  logic                                                      sample_valid,
  output logic [jesd_tpl_pkg::jesd_l*jesd_tpl_pkg::lane_width-1:0] lane_data,
  output logic                                                      lane_valid
);

  import jesd_tpl_pkg::*;

  // Lane words in the order they go out, before the register
  logic [jesd_l*lane_width-1:0] lane_next;

  // ********************************************************
  // Octet mapping
  // ********************************************************

  // Frame octet 0 is the most significant octet of the frame.
  // Lane k takes frame octets lane_bytes*k onward, first one in its MSB.
  // Lane k sits at bits k*lane_width upward of the lane bus
  always_comb begin
    lane_next = '0;
    for (int k = 0; k < jesd_l; k++) begin
      for (int b = 0; b < lane_bytes; b++) begin
        lane_next[k * lane_width + lane_width - 1 - 8 * b -: 8] =
          samples[frame_width - 1 - 8 * (k * lane_bytes + b) -: 8];
      end
    end
  end

  // One pipeline stage, the lane bus follows the sample bus a cycle later
  always_ff @(posedge device_clk) begin
    if (reset) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= sample_valid;
    end
  end

  // Lane words carry no reset, only the qualifier does
  always_ff @(posedge device_clk) begin
    lane_data <= lane_next;
  end

  // The qualifier is delayed by exactly one cycle and never stretched or dropped
  a_valid_one_cycle : assert property (
    @(posedge device_clk) !reset |=> (lane_valid == $past(sample_valid))
  );

endmodule
